//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_cpu
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// data bus and register width
`define DATA_W 8
// address bus and pc width
`define ADDR_W 16

// flag bit positions, flags live in the upper nibble of the F byte
`define FLAG_Z 7
`define FLAG_N 6
`define FLAG_H 5
`define FLAG_C 4

// upper address byte for LDH (a8),A
`define HIGH_PAGE 8'hFF
// first fetch address after reset
`define RESET_PC 16'h0000

// opcodes with special handling in the decoder
`define OP_HALT 8'h76
`define OP_LDH_STORE 8'hE0

// register select code 6 picks the immediate latch, not a register
`define SRC_IMM 3'd6
// register select code of the accumulator
`define REG_A 3'd7

`endif

//--- common/cpu_pkg.sv
package cpu_pkg;

	// register form, used by LD, the ALU group and INC/DEC
	typedef struct packed {
		logic [1:0] group;
		logic [2:0] dst;
		logic [2:0] src;
	} op_reg_t;

	// jump form, used by JP and JP cc
	typedef struct packed {
		logic [1:0] group;
		logic       zero;
		logic [1:0] cond;
		logic [2:0] low;
	} op_jump_t;

	// one opcode byte, seen either way
	typedef union packed {
		op_reg_t  r;
		op_jump_t j;
	} opcode_u;

	// alu operations in opcode order (bits 5:3 of the ALU group)
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_ADC,
		ALU_SUB,
		ALU_SBC,
		ALU_AND,
		ALU_XOR,
		ALU_OR,
		ALU_CP
	} alu_op_e;

	// machine cycle kinds
	typedef enum logic [2:0] {
		FETCH_OP,
		FETCH_IMML,
		FETCH_IMMH,
		JUMP,
		STORE
	} mstate_e;

endpackage

//--- decode/op_decoder.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module op_decoder (
	input  cpu_pkg::opcode_u          opcode,
	input  cpu_pkg::mstate_e          state,
	input  logic [`FLAG_Z:`FLAG_C]    flags,
	output cpu_pkg::mstate_e          next_state,
	output logic                      jump_load,
	output logic                      halt_req,
	output logic [2:0]                src_sel,
	output logic [2:0]                dst_sel,
	output logic                      wb_alu,
	output logic                      reg_we,
	output logic [`FLAG_Z:`FLAG_C]    flag_we,
	output logic                      incdec,
	output logic                      dec,
	output cpu_pkg::alu_op_e          alu_op
);
	import cpu_pkg::*;

	logic cond_met;

	// cond bit 1 picks C over Z, cond bit 0 is the required value
	// low bit 0 set means JP a16 without a condition
	assign cond_met = opcode.j.low[0] ||
		(flags[opcode.j.cond[1] ? `FLAG_C : `FLAG_Z] == opcode.j.cond[0]);

	always_comb
	begin
		// everything not matched below is a one machine cycle NOP
		next_state = FETCH_OP;
		jump_load  = 1'b0;
		halt_req   = 1'b0;
		src_sel    = opcode.r.src;
		dst_sel    = opcode.r.dst;
		wb_alu     = 1'b0;
		reg_we     = 1'b0;
		flag_we    = '0;
		alu_op     = alu_op_e'(opcode.r.dst);
		incdec     = 1'b0;
		dec        = 1'b0;

		case (opcode.r.group)
			2'b00:
			begin
				if ((opcode.r.src == `SRC_IMM) && (opcode.r.dst != `SRC_IMM))
				begin
					// LD r,d8 fetches its byte, then copies it
					if (state == FETCH_OP)
						next_state = FETCH_IMML;
					else if (state == FETCH_IMML)
					begin
						src_sel = `SRC_IMM;
						reg_we  = 1'b1;
					end
				end
				else if ((opcode.r.src[2:1] == 2'b10) && (opcode.r.dst != `SRC_IMM))
				begin
					// INC r / DEC r, carry untouched
					src_sel = opcode.r.dst;
					incdec  = 1'b1;
					dec     = opcode.r.src[0];
					wb_alu  = 1'b1;
					reg_we  = 1'b1;
					flag_we = '1;
					flag_we[`FLAG_C] = 1'b0;
				end
			end
			2'b01:
			begin
				// HALT sits where LD (HL),(HL) would be
				if (opcode == `OP_HALT)
					halt_req = 1'b1;
				else if ((opcode.r.src != `SRC_IMM) && (opcode.r.dst != `SRC_IMM))
					reg_we = 1'b1;
			end
			2'b10:
			begin
				// ALU A,r
				if (opcode.r.src != `SRC_IMM)
				begin
					dst_sel = `REG_A;
					wb_alu  = 1'b1;
					reg_we  = (alu_op != ALU_CP);
					flag_we = '1;
				end
			end
			default:
			begin
				if (opcode.r.src == `SRC_IMM)
				begin
					// ALU A,d8
					if (state == FETCH_OP)
						next_state = FETCH_IMML;
					else if (state == FETCH_IMML)
					begin
						src_sel = `SRC_IMM;
						dst_sel = `REG_A;
						wb_alu  = 1'b1;
						reg_we  = (alu_op != ALU_CP);
						flag_we = '1;
					end
				end
				else if (opcode == `OP_LDH_STORE)
				begin
					// offset byte, then one store machine cycle
					if (state == FETCH_OP)
						next_state = FETCH_IMML;
					else if (state == FETCH_IMML)
						next_state = STORE;
				end
				else if (!opcode.j.zero && ((opcode.j.low == 3'b010) ||
					((opcode.j.low == 3'b011) && (opcode.j.cond == 2'b00))))
				begin
					// JP a16 and JP cc,a16, an extra cycle only when taken
					case (state)
						FETCH_OP:   next_state = FETCH_IMML;
						FETCH_IMML: next_state = FETCH_IMMH;
						FETCH_IMMH: next_state = cond_met ? JUMP : FETCH_OP;
						JUMP:       jump_load  = 1'b1;
						default:    ;
					endcase
				end
			end
		endcase
	end

endmodule

//--- execute/alu.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module alu (
	input  logic [`DATA_W-1:0]        a_val,
	input  logic [`DATA_W-1:0]        src_val,
	input  cpu_pkg::alu_op_e          alu_op,
	input  logic                      incdec,
	input  logic                      dec,
	input  logic                      carry_in,
	output logic [`DATA_W-1:0]        result,
	output logic [`FLAG_Z:`FLAG_C]    new_flags
);
	import cpu_pkg::*;

	// bit 8 holds carry out or borrow
	logic [`DATA_W:0] wide;
	logic             cin;
	logic             sub;
	logic             half;

	// only ADC and SBC pull in the old carry
	assign cin = ((alu_op == ALU_ADC) || (alu_op == ALU_SBC)) ? carry_in : 1'b0;

	always_comb
	begin
		wide = '0;
		sub  = 1'b0;
		half = 1'b0;
		if (incdec)
		begin
			// inc/dec on the selected register
			if (dec)
				wide = {1'b0, src_val} - 1'b1;
			else
				wide = {1'b0, src_val} + 1'b1;
			sub  = dec;
			// operand bit 4 is zero so the tap is src ^ result
			half = src_val[4] ^ wide[4];
		end
		else
		begin
			case (alu_op)
				ALU_ADD, ALU_ADC:
				begin
					wide = {1'b0, a_val} + {1'b0, src_val} + {{`DATA_W{1'b0}}, cin};
					half = a_val[4] ^ src_val[4] ^ wide[4];
				end
				ALU_AND:
				begin
					wide = {1'b0, a_val & src_val};
					half = 1'b1;
				end
				ALU_XOR: wide = {1'b0, a_val ^ src_val};
				ALU_OR:  wide = {1'b0, a_val | src_val};
				default:
				begin
					// SUB, SBC and CP share the subtractor
					wide = {1'b0, a_val} - {1'b0, src_val} - {{`DATA_W{1'b0}}, cin};
					sub  = 1'b1;
					half = a_val[4] ^ src_val[4] ^ wide[4];
				end
			endcase
		end

		result = wide[`DATA_W-1:0];
		new_flags[`FLAG_Z] = (result == '0);
		new_flags[`FLAG_N] = sub;
		new_flags[`FLAG_H] = half;
		// inc/dec passes the old carry through
		new_flags[`FLAG_C] = incdec ? carry_in : wide[`DATA_W];
	end

endmodule

//--- logic/bus_sequencer.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module bus_sequencer (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [`DATA_W-1:0]   din,
	input  logic [`DATA_W-1:0]   a_val,
	input  cpu_pkg::mstate_e     next_state,
	input  logic                 jump_load,
	input  logic                 halt_req,
	output cpu_pkg::opcode_u     opcode,
	output cpu_pkg::mstate_e     state,
	output logic [`DATA_W-1:0]   imml,
	output logic [`DATA_W-1:0]   immh,
	output logic                 commit,
	output logic [`ADDR_W-1:0]   adr,
	output logic [`DATA_W-1:0]   dout,
	output logic                 read,
	output logic                 write,
	output logic [`ADDR_W-1:0]   pc,
	output logic                 halted
);
	import cpu_pkg::*;

	logic [1:0] cycle;
	logic [1:0] cycle_nxt;
	mstate_e    state_nxt;
	logic       halted_nxt;
	logic       fetch;
	logic       fetch_nxt;

	// machine cycles that read a byte at pc
	assign fetch     = (state == FETCH_OP) || (state == FETCH_IMML) || (state == FETCH_IMMH);
	assign fetch_nxt = (state_nxt == FETCH_OP) || (state_nxt == FETCH_IMML) ||
		(state_nxt == FETCH_IMMH);

	// counter freezes once halted until the next reset
	assign cycle_nxt  = halted ? cycle : cycle + 2'd1;
	// decoder result is taken only at the end of cycle 3
	assign state_nxt  = (cycle == 2'd3) ? next_state : state;
	assign halted_nxt = halted || ((cycle == 2'd3) && halt_req);

	// one commit strobe in the last clock of each machine cycle
	assign commit = (cycle == 2'd3) && !halted;

	// store goes to the high page and every other state addresses pc
	assign adr  = (state == STORE) ? {`HIGH_PAGE, imml} : pc;
	assign dout = a_val;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			cycle  <= 2'd0;
			state  <= FETCH_OP;
			pc     <= `RESET_PC;
			halted <= 1'b0;
			read   <= 1'b0;
			write  <= 1'b0;
		end
		else
		begin
			cycle  <= cycle_nxt;
			state  <= state_nxt;
			halted <= halted_nxt;
			// bus levels are set up one clock ahead
			// read covers cycles 0 to 2 of a fetch
			read   <= !halted_nxt && fetch_nxt && (cycle_nxt != 2'd3);
			// write covers cycles 0 and 1 of a store
			write  <= !halted_nxt && (state_nxt == STORE) && !cycle_nxt[1];
			if (commit && jump_load)
				pc <= {immh, imml};
			else if (fetch && (cycle == 2'd1))
				pc <= pc + 1'b1;
		end
	end

	// instruction latches, filled at the end of cycle 2
	always_ff @(posedge clk)
	begin
		if (cycle == 2'd2)
		begin
			case (state)
				FETCH_OP:   opcode <= din;
				FETCH_IMML: imml   <= din;
				FETCH_IMMH: immh   <= din;
				default:    ;
			endcase
		end
	end

	// memory never sees a read and a write in the same clock
	assert property (@(posedge clk) disable iff (reset) !(read && write));

	// a pc load from the immediates belongs to a JUMP machine cycle
	assert property (@(posedge clk) disable iff (reset) (commit && jump_load) |-> (state == JUMP));

endmodule

//--- logic/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_top (
	input  logic                      clk,
	input  logic                      reset,
	input  logic [`DATA_W-1:0]        din,
	output logic [`ADDR_W-1:0]        adr,
	output logic [`DATA_W-1:0]        dout,
	output logic                      read,
	output logic                      write,
	output logic                      halted,
	output logic [`ADDR_W-1:0]        pc,
	output logic [`FLAG_Z:`FLAG_C]    flags
);
	import cpu_pkg::*;

	// sequencer outputs
	opcode_u                   opcode;
	mstate_e                   state;
	logic [`DATA_W-1:0]        imml;
	logic [`DATA_W-1:0]        immh;
	logic                      commit;

	// decoder outputs
	mstate_e                   next_state;
	logic                      jump_load;
	logic                      halt_req;
	logic [2:0]                src_sel;
	logic [2:0]                dst_sel;
	logic                      wb_alu;
	logic                      reg_we;
	logic [`FLAG_Z:`FLAG_C]    flag_we;
	alu_op_e                   alu_op;
	logic                      incdec;
	logic                      dec;

	// datapath
	logic [`DATA_W-1:0]        src_val;
	logic [`DATA_W-1:0]        a_val;
	logic [`DATA_W-1:0]        result;
	logic [`FLAG_Z:`FLAG_C]    new_flags;

	bus_sequencer u_seq (
		.clk        (clk),
		.reset      (reset),
		.din        (din),
		.a_val      (a_val),
		.next_state (next_state),
		.jump_load  (jump_load),
		.halt_req   (halt_req),
		.opcode     (opcode),
		.state      (state),
		.imml       (imml),
		.immh       (immh),
		.commit     (commit),
		.adr        (adr),
		.dout       (dout),
		.read       (read),
		.write      (write),
		.pc         (pc),
		.halted     (halted)
	);

	op_decoder u_dec (
		.opcode     (opcode),
		.state      (state),
		.flags      (flags),
		.next_state (next_state),
		.jump_load  (jump_load),
		.halt_req   (halt_req),
		.src_sel    (src_sel),
		.dst_sel    (dst_sel),
		.wb_alu     (wb_alu),
		.reg_we     (reg_we),
		.flag_we    (flag_we),
		.alu_op     (alu_op),
		.incdec     (incdec),
		.dec        (dec)
	);

	// carry in comes straight from the committed C flag
	alu u_alu (
		.a_val     (a_val),
		.src_val   (src_val),
		.alu_op    (alu_op),
		.incdec    (incdec),
		.dec       (dec),
		.carry_in  (flags[`FLAG_C]),
		.result    (result),
		.new_flags (new_flags)
	);

	reg_file u_regs (
		.clk       (clk),
		.reset     (reset),
		.commit    (commit),
		.src_sel   (src_sel),
		.dst_sel   (dst_sel),
		.imml      (imml),
		.wb_alu    (wb_alu),
		.reg_we    (reg_we),
		.flag_we   (flag_we),
		.result    (result),
		.new_flags (new_flags),
		.src_val   (src_val),
		.a_val     (a_val),
		.flags     (flags)
	);

endmodule

//--- result/reg_file.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module reg_file (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      commit,
	input  logic [2:0]                src_sel,
	input  logic [2:0]                dst_sel,
	input  logic [`DATA_W-1:0]        imml,
	input  logic                      wb_alu,
	input  logic                      reg_we,
	input  logic [`FLAG_Z:`FLAG_C]    flag_we,
	input  logic [`DATA_W-1:0]        result,
	input  logic [`FLAG_Z:`FLAG_C]    new_flags,
	output logic [`DATA_W-1:0]        src_val,
	output logic [`DATA_W-1:0]        a_val,
	output logic [`FLAG_Z:`FLAG_C]    flags
);

	// B C D E H L at codes 0..5, A at 7
	// code 6 is the immediate and is never stored here
	logic [`DATA_W-1:0] regs [0:7];
	logic [`DATA_W-1:0] wr_data;

	// source operand for LD and the alu
	assign src_val = (src_sel == `SRC_IMM) ? imml : regs[src_sel];
	assign a_val   = regs[`REG_A];

	// loads copy the source, arithmetic takes the alu result
	assign wr_data = wb_alu ? result : src_val;

	always_ff @(posedge clk)
	begin
		if (commit && reg_we && (dst_sel != `SRC_IMM))
			regs[dst_sel] <= wr_data;
	end

	// per-flag write mask, inc/dec leaves C alone
	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else if (commit)
			flags <= (flags & ~flag_we) | (new_flags & flag_we);
	end

endmodule

//--- sim/tb_cpu.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_cpu;

	localparam integer CLK_PERIOD = 10;
	// programs run in total, each one gets 200 machine cycles of watchdog budget
	localparam integer RUNS = 58;
	// clocks a single program may take before it counts as hung
	localparam integer HALT_LIMIT = 150 * 4;

	logic        clk;
	logic        reset;
	logic [7:0]  din = 8'h00;
	logic [15:0] adr;
	logic [7:0]  dout;
	logic        read;
	logic        write;
	logic        halted;
	logic [15:0] pc;
	logic [7:4]  flags;

	// 64 KB memory and the bus model state
	logic [7:0]  mem [0:65535];
	logic [15:0] rd_adr = 16'h0000;
	logic        read_prev = 1'b0;
	logic        write_prev = 1'b0;
	logic [15:0] first_rd = 16'hFFFF;
	logic        first_seen = 1'b0;
	// store log, one entry per write pulse
	logic [15:0] st_adr [$];
	logic [7:0]  st_dat [$];

	logic [15:0] ptr;
	integer      seed;
	integer      errors;
	integer      runs;

	cpu_top u_dut (
		.clk    (clk),
		.reset  (reset),
		.din    (din),
		.adr    (adr),
		.dout   (dout),
		.read   (read),
		.write  (write),
		.halted (halted),
		.pc     (pc),
		.flags  (flags)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// memory and bus monitor, all on the falling edge
	always @(negedge clk)
	begin
		if (reset)
		begin
			first_seen = 1'b0;
			st_adr.delete();
			st_dat.delete();
		end
		// memory takes the address when a read access starts and holds it
		if (read && !read_prev)
		begin
			rd_adr = adr;
			if (!first_seen)
			begin
				first_rd   = adr;
				first_seen = 1'b1;
			end
		end
		read_prev = read;
		din <= mem[rd_adr];
		if (write && !write_prev)
		begin
			st_adr.push_back(adr);
			st_dat.push_back(dout);
		end
		write_prev = write;
	end

	// reference alu, returns {Z, N, H, C, result}
	function automatic logic [11:0] alu_expect(input logic [2:0] op, input logic [7:0] a,
		input logic [7:0] b, input logic cin);
		integer     ia;
		integer     ib;
		integer     ci;
		integer     s;
		integer     lo;
		logic       n;
		logic       h;
		logic       c;
		logic [7:0] r;
		ia = a;
		ib = b;
		// only ADC and SBC see the old carry
		ci = ((op == 3'd1) || (op == 3'd3)) ? cin : 0;
		s  = 0;
		lo = 0;
		n  = 1'b0;
		h  = 1'b0;
		c  = 1'b0;
		case (op)
			3'd0, 3'd1:
			begin
				s  = ia + ib + ci;
				lo = (ia % 16) + (ib % 16) + ci;
				h  = (lo > 15);
				c  = (s > 255);
			end
			3'd4:
			begin
				s = ia & ib;
				h = 1'b1;
			end
			3'd5: s = ia ^ ib;
			3'd6: s = ia | ib;
			default:
			begin
				// SUB, SBC and CP borrow when the subtrahend is larger
				s  = ia - ib - ci;
				lo = (ia % 16) - (ib % 16) - ci;
				n  = 1'b1;
				h  = (lo < 0);
				c  = (s < 0);
			end
		endcase
		r = s[7:0];
		return {(r == 8'h00), n, h, c, r};
	endfunction

	task automatic report_fail(input string msg);
		errors++;
		$display("FAIL %0t: %s", $time, msg);
	endtask

	task automatic clear_memory;
		integer i;
		for (i = 0; i < 65536; i++)
			mem[i] = 8'h00;
		ptr = 16'h0000;
	endtask

	task automatic emit(input logic [7:0] b);
		mem[ptr] = b;
		ptr++;
	endtask

	task automatic apply_reset;
		@(negedge clk);
		reset = 1'b1;
		repeat (4) @(negedge clk);
		reset = 1'b0;
		runs++;
	endtask

	task automatic run_to_halt;
		integer n;
		n = 0;
		while (!halted && (n < HALT_LIMIT))
		begin
			@(negedge clk);
			n++;
		end
		if (!halted)
		begin
			errors++;
			$display("ERROR at %0t: core did not reach HALT within %0d clocks, pc is %h",
				$time, HALT_LIMIT, pc);
		end
	endtask

	task automatic expect_store(input integer idx, input logic [15:0] a, input logic [7:0] d);
		if (st_adr.size() <= idx)
			report_fail($sformatf("store %0d missing, expected %h to %h", idx, d, a));
		else if ((st_adr[idx] !== a) || (st_dat[idx] !== d))
			report_fail($sformatf("store %0d wrote %h to %h, expected %h to %h",
				idx, st_dat[idx], st_adr[idx], d, a));
	endtask

	// bus idle and pc at its reset value, first fetch from address 0
	task automatic reset_state_check;
		clear_memory;
		emit(`OP_HALT);
		apply_reset;
		if ((read !== 1'b0) || (write !== 1'b0))
			report_fail($sformatf("read %b write %b after reset, expected 0 0", read, write));
		if (pc !== `RESET_PC)
			report_fail($sformatf("pc %h after reset, expected %h", pc, `RESET_PC));
		if (halted !== 1'b0)
			report_fail("halted high after reset");
		run_to_halt;
		if (!first_seen || (first_rd !== 16'h0000))
			report_fail($sformatf("first read at %h, expected 0000", first_rd));
		if (pc !== 16'h0001)
			report_fail($sformatf("pc %h after HALT at 0000, expected 0001", pc));
		if (st_adr.size() != 0)
			report_fail($sformatf("%0d stores from a lone HALT", st_adr.size()));
	endtask

	task automatic load_store_sequence;
		logic [7:0] vals [0:6];
		logic [2:0] code;
		integer     i;
		clear_memory;
		for (i = 0; i < 7; i++)
		begin
			// B C D E H L, then A at code 7
			code    = (i == 6) ? 3'd7 : 3'(i);
			vals[i] = 8'($random(seed));
			emit({2'b00, code, 3'b110});
			emit(vals[i]);
		end
		// A is stored first, LD A,r overwrites it later
		emit(`OP_LDH_STORE);
		emit(8'h26);
		for (i = 0; i < 6; i++)
		begin
			emit({5'b01111, 3'(i)});
			emit(`OP_LDH_STORE);
			emit(8'h20 + 8'(i));
		end
		emit(`OP_HALT);
		apply_reset;
		run_to_halt;
		if (st_adr.size() != 7)
			report_fail($sformatf("%0d stores from the load program, expected 7", st_adr.size()));
		expect_store(0, 16'hFF26, vals[6]);
		for (i = 0; i < 6; i++)
			expect_store(i + 1, 16'hFF20 + 16'(i), vals[i]);
	endtask

	task automatic alu_group_cases;
		logic [7:0]  x;
		logic [7:0]  y;
		logic [7:0]  a;
		logic [7:0]  b;
		logic [7:0]  off;
		logic [2:0]  opc;
		logic [2:0]  r;
		logic        cin;
		logic [11:0] exp;
		integer      op;
		integer      k;
		for (op = 0; op < 8; op++)
			for (k = 0; k < 4; k++)
			begin
				opc = 3'(op);
				r   = 3'((op + k) % 6);
				x   = 8'($random(seed));
				y   = 8'($random(seed));
				a   = 8'($random(seed));
				// the last pair has equal operands, zero for SUB, XOR and CP
				b   = (k == 3) ? a : 8'($random(seed));
				cin = (({1'b0, x} + {1'b0, y}) > 9'h0FF);
				off = 8'h40 + 8'(op * 4 + k);
				clear_memory;
				// ADD A,y leaves the carry that ADC and SBC pick up
				emit(8'h3E);
				emit(x);
				emit(8'hC6);
				emit(y);
				emit(8'h3E);
				emit(a);
				if (k[0])
				begin
					emit({2'b11, opc, 3'b110});
					emit(b);
				end
				else
				begin
					emit({2'b00, r, 3'b110});
					emit(b);
					emit({2'b10, opc, r});
				end
				emit(`OP_LDH_STORE);
				emit(off);
				emit(`OP_HALT);
				apply_reset;
				run_to_halt;
				exp = alu_expect(opc, a, b, cin);
				if (st_adr.size() != 1)
					report_fail($sformatf("alu op %0d made %0d stores", op, st_adr.size()));
				// CP leaves A as it was
				expect_store(0, {8'hFF, off}, (opc == 3'd7) ? a : exp[7:0]);
				if (flags !== exp[11:8])
					report_fail($sformatf("alu op %0d on %h,%h cin %b flags %b, expected %b",
						op, a, b, cin, flags, exp[11:8]));
			end
	endtask

	task automatic incdec_wrap;
		logic [7:0] v;
		logic [7:0] res;
		logic [2:0] r;
		logic [3:0] exp_f;
		logic       dec;
		logic       cprev;
		integer     k;
		for (k = 0; k < 6; k++)
		begin
			v     = (k < 2) ? 8'h0F : ((k < 4) ? 8'hFF : 8'h00);
			dec   = k[0];
			r     = (k == 5) ? 3'd7 : 3'(k);
			cprev = k[1];
			res   = dec ? (v - 8'd1) : (v + 8'd1);
			// H from the low nibble wrapping, C kept from before
			exp_f = {(res == 8'h00), dec, dec ? (v[3:0] == 4'h0) : (v[3:0] == 4'hF), cprev};
			clear_memory;
			emit(8'h3E);
			emit(cprev ? 8'h80 : 8'h01);
			emit(8'hC6);
			emit(cprev ? 8'h80 : 8'h01);
			emit({2'b00, r, 3'b110});
			emit(v);
			emit({2'b00, r, 2'b10, dec});
			if (r != 3'd7)
				emit({5'b01111, r});
			emit(`OP_LDH_STORE);
			emit(8'h50 + 8'(k));
			emit(`OP_HALT);
			apply_reset;
			run_to_halt;
			expect_store(0, 16'hFF50 + 16'(k), res);
			if (flags !== exp_f)
				report_fail($sformatf("%s of %h flags %b, expected %b",
					dec ? "DEC" : "INC", v, flags, exp_f));
		end
	endtask

	task automatic conditional_jumps;
		logic [7:0] x;
		logic [7:0] y;
		logic [7:0] op;
		logic       z;
		logic       c;
		logic       taken;
		integer     cond;
		integer     fl;
		for (cond = 0; cond < 5; cond++)
			for (fl = 0; fl < 4; fl++)
				if ((cond < 4) || (fl == 0))
				begin
					z = fl[1];
					c = fl[0];
					// ADD operands that leave exactly this Z and C
					x = (fl == 0) ? 8'h01 : ((fl == 1) ? 8'hFF : ((fl == 2) ? 8'h00 : 8'h80));
					y = (fl == 1) ? 8'h02 : x;
					// NZ Z NC C, code 4 here stands for plain JP a16
					if (cond == 4)
						taken = 1'b1;
					else if (cond >= 2)
						taken = (c == cond[0]);
					else
						taken = (z == cond[0]);
					op = (cond == 4) ? 8'hC3 : {3'b110, 2'(cond), 3'b010};
					clear_memory;
					emit(8'h3E);
					emit(x);
					emit(8'hC6);
					emit(y);
					emit(op);
					emit(8'h40);
					emit(8'h00);
					// fall-through path
					emit(8'h3E);
					emit(8'h11);
					emit(`OP_LDH_STORE);
					emit(8'h01);
					emit(`OP_HALT);
					// jump target
					ptr = 16'h0040;
					emit(8'h3E);
					emit(8'h22);
					emit(`OP_LDH_STORE);
					emit(8'h02);
					emit(`OP_HALT);
					apply_reset;
					run_to_halt;
					if (st_adr.size() != 1)
						report_fail($sformatf("jump cond %0d made %0d stores", cond, st_adr.size()));
					if (taken)
						expect_store(0, 16'hFF02, 8'h22);
					else
						expect_store(0, 16'hFF01, 8'h11);
					if (pc !== (taken ? 16'h0045 : 16'h000C))
						report_fail($sformatf("jump cond %0d z %b c %b ended at pc %h",
							cond, z, c, pc));
				end
	endtask

	task automatic halt_freeze;
		logic [15:0] hold;
		logic        moved;
		integer      n;
		clear_memory;
		emit(8'h3E);
		emit(8'h5A);
		emit(`OP_LDH_STORE);
		emit(8'h30);
		emit(`OP_HALT);
		// never reached while halted
		emit(8'h3E);
		emit(8'hA5);
		emit(`OP_LDH_STORE);
		emit(8'h31);
		emit(`OP_HALT);
		apply_reset;
		run_to_halt;
		hold  = pc;
		moved = 1'b0;
		for (n = 0; n < 40; n++)
		begin
			@(negedge clk);
			if ((pc !== hold) || read || write || !halted)
				moved = 1'b1;
		end
		if (moved)
			report_fail("pc, read or write changed after HALT");
		if (hold !== 16'h0005)
			report_fail($sformatf("pc %h while halted, expected 0005", hold));
		if (st_adr.size() != 1)
			report_fail($sformatf("%0d stores around HALT, expected 1", st_adr.size()));
		expect_store(0, 16'hFF30, 8'h5A);
	endtask

	initial
	begin
		clk    = 1'b0;
		reset  = 1'b1;
		seed   = 32'he4fa;
		errors = 0;
		runs   = 0;
		reset_state_check;
		load_store_sequence;
		alu_group_cases;
		incdec_wrap;
		conditional_jumps;
		halt_freeze;
		$display("tb_cpu: %0d programs run, %0d errors", runs, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	// watchdog sized from the number of programs
	initial
	begin
		#(RUNS * 200 * 4 * CLK_PERIOD);
		$display("ERROR: watchdog expired before all programs finished");
		$display("Test failures found");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+common
common/cpu_pkg.sv
logic/bus_sequencer.sv
decode/op_decoder.sv
execute/alu.sv
result/reg_file.sv
logic/cpu_top.sv
sim/tb_cpu.sv
